//--- src/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// datapath widths
`define DATA_W      16
`define REG_COUNT   8
`define REG_ADDR_W  3

// host port address width, only the low REG_ADDR_W bits select a register
`define APB_ADDR_W  4

// ***************************************************************************
// opcode values, instruction bits 2..0
// ***************************************************************************
`define OP_RTYPE    3'd0
`define OP_ADDI     3'd1
`define OP_LOAD     3'd2
`define OP_STORE    3'd3
`define OP_BEQ      3'd4
`define OP_BNE      3'd5
`define OP_JAL      3'd6
`define OP_JR       3'd7

`endif

//--- src/decodePkg.sv
`default_nettype none
`include "decode_params.svh"

package decodePkg;

    typedef logic [`DATA_W-1:0]     wordT;
    typedef logic [`REG_ADDR_W-1:0] regAddrT;
    typedef logic [15:0]            instrT;
    typedef logic [3:0]             funcT;
    typedef logic [2:0]             aluOpT;
    typedef logic [1:0]             regStoreT;   // writeback source select

    localparam aluOpT    aluAdd   = 3'd0;
    localparam regStoreT storeAlu = 2'd0;
    localparam regStoreT storeMem = 2'd1;
    localparam regStoreT storePc2 = 2'd2;

    typedef enum logic [2:0] {
        opRtype = `OP_RTYPE,
        opAddi  = `OP_ADDI,
        opLoad  = `OP_LOAD,
        opStore = `OP_STORE,
        opBeq   = `OP_BEQ,
        opBne   = `OP_BNE,
        opJal   = `OP_JAL,
        opJr    = `OP_JR
    } opcodeE;

    typedef struct packed {
        wordT  pc;
        wordT  pcPlus2;
        instrT ir;
    } ifIdT;

    typedef struct packed {
        logic     regWrite;
        logic     aluSrc;     // second ALU operand is the immediate
        aluOpT    aluOp;
        logic     memWrite;
        logic     memRead;
        regStoreT regStore;
        logic     branch;
        logic     jump;
        logic     jumpReg;
    } ctrlT;

    typedef struct packed {
        logic    write;
        regAddrT addr;
        wordT    data;
    } wbT;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        wordT                   pwdata;
    } apbReqT;

    typedef struct packed {
        logic pready;
        wordT prdata;
    } apbRspT;

    typedef struct packed {
        wordT arg1;   // Rs1
        wordT arg2;   // Rs2
        wordT arg3;   // Rd, also the JR target
    } operandsT;

endpackage

`default_nettype wire

//--- src/ifIdLatch.sv
`default_nettype none

module ifIdLatch
    import decodePkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic latchEn,
    input  wire ifIdT fetchIn,
    output ifIdT      stage
);

    // an all zero ir is an R-type add into r0, so reset leaves a bubble behind
    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= '0;
        end else if (latchEn) begin
            stage <= fetchIn;
        end
        // with latchEn low the stage holds while the pipeline is stalled
    end

endmodule

`default_nettype wire

//--- src/controlDecoder.sv
`default_nettype none

module controlDecoder
    import decodePkg::*;
(
    input  wire instrT ir,
    output ctrlT       ctrl
);

    opcodeE  opcode;
    funcT    func;
    regAddrT rd;
    logic    writesRd;

    assign opcode = opcodeE'(ir[2:0]);
    assign func   = ir[15:12];
    assign rd     = ir[5:3];

    // ***********************************************************************
    // control word
    // ***********************************************************************
    always_comb begin
        ctrl     = '0;
        writesRd = 1'b0;
        ctrl.aluOp    = aluAdd;
        ctrl.regStore = storeAlu;

        case (opcode)
            opRtype: begin
                writesRd = 1'b1;
                // only eight ALU operations exist, larger codes fall back to add
                ctrl.aluOp = (func > 4'd7) ? aluAdd : func[2:0];
            end
            opAddi: begin
                writesRd    = 1'b1;
                ctrl.aluSrc = 1'b1;
            end
            opLoad: begin
                writesRd      = 1'b1;
                ctrl.aluSrc   = 1'b1;   // address is base plus offset
                ctrl.memRead  = 1'b1;
                ctrl.regStore = storeMem;
            end
            opStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq, opBne: begin
                ctrl.branch = 1'b1;
            end
            opJal: begin
                writesRd      = 1'b1;
                ctrl.jump     = 1'b1;
                ctrl.regStore = storePc2;   // link register gets the return address
            end
            opJr: begin
                ctrl.jump    = 1'b1;
                ctrl.jumpReg = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase

        // writes into r0 are dropped here so bubbles never update a register
        ctrl.regWrite = writesRd && (rd != '0);
    end

    // a memory access is either a load or a store, the memory stage relies on it
    assert final (!(ctrl.memRead && ctrl.memWrite))
        else $error("memRead and memWrite decoded together for ir %h", ir);

endmodule

`default_nettype wire

//--- src/registerFile.sv
`default_nettype none
`include "decode_params.svh"

module registerFile
    import decodePkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire regAddrT rs1,
    input  wire regAddrT rs2,
    input  wire regAddrT rd,
    input  wire wbT      wb,
    input  wire apbReqT  apbReq,
    output apbRspT       apbRsp,
    output operandsT     operands
);

    wordT    regs [`REG_COUNT];
    regAddrT apbAddr;
    logic    setupPhase;
    logic    accessPhase;
    logic    apbWrite;
    regAddrT wrAddr;
    wordT    wrData;
    logic    wrEn;

    assign apbAddr     = apbReq.paddr[`REG_ADDR_W-1:0];   // upper address bits ignored
    assign setupPhase  = apbReq.psel && !apbReq.penable;
    assign accessPhase = apbReq.psel && apbReq.penable;

    // ***********************************************************************
    // host port, held off for any cycle with a writeback
    // ***********************************************************************
    assign apbRsp.pready = !wb.write;
    assign apbRsp.prdata = accessPhase ? regs[apbAddr] : '0;

    assign apbWrite = accessPhase && apbReq.pwrite && apbRsp.pready;

    // the two sources never meet because pready is low whenever wb.write is high
    assign wrAddr = wb.write ? wb.addr : apbAddr;
    assign wrData = wb.write ? wb.data : apbReq.pwdata;
    assign wrEn   = (wb.write || apbWrite) && (wrAddr != '0);   // r0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // reads see the array before the edge, so a same-cycle write shows up next cycle
    assign operands.arg1 = regs[rs1];
    assign operands.arg2 = regs[rs2];
    assign operands.arg3 = regs[rd];

    // ***********************************************************************
    // checks
    // ***********************************************************************

    // an access phase is entered from setup or continues a stalled access
    assert property (@(posedge clk) disable iff (rst)
        accessPhase |-> $stable(apbReq.paddr) &&
            ($past(setupPhase) || $past(accessPhase && !apbRsp.pready)))
        else $error("APB access phase without a matching setup phase");

    assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("r0 was written");

endmodule

`default_nettype wire

//--- src/immediateGen.sv
`default_nettype none

module immediateGen
    import decodePkg::*;
(
    input  wire instrT ir,
    output wordT       imm
);

    opcodeE opcode;

    assign opcode = opcodeE'(ir[2:0]);

    always_comb begin
        case (opcode)
            opAddi, opLoad: begin
                imm = {{9{ir[15]}}, ir[15:9]};
            end
            opStore, opBeq, opBne: begin
                // split field because bits 11..6 hold the two source registers
                imm = {{9{ir[15]}}, ir[15:12], ir[5:3]};
            end
            opJal: begin
                imm = {{2{ir[15]}}, ir[15:3], 1'b0};   // halfword offset
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/branchUnit.sv
`default_nettype none

module branchUnit
    import decodePkg::*;
(
    input  wire wordT     pc,
    input  wire ctrlT     ctrl,
    input  wire instrT    ir,
    input  wire operandsT operands,
    input  wire wordT     imm,
    input  wire logic     fwdSel1,
    input  wire logic     fwdSel2,
    input  wire wordT     fwdData,
    output wordT          newPc,
    output logic          branchTaken
);

    wordT   cmpA;
    wordT   cmpB;
    wordT   pcTarget;
    logic   equal;
    logic   condMet;
    opcodeE opcode;

    assign opcode = opcodeE'(ir[2:0]);

    // ***********************************************************************
    // compare with forwarding
    // ***********************************************************************

    // the hazard unit picks fwdData when a result is still in flight
    assign cmpA = fwdSel1 ? fwdData : operands.arg1;
    assign cmpB = fwdSel2 ? fwdData : operands.arg2;

    assign equal   = (cmpA == cmpB);
    assign condMet = (opcode == opBne) ? !equal : equal;

    assign branchTaken = ctrl.jump || (ctrl.branch && condMet);

    // ***********************************************************************
    // target
    // ***********************************************************************
    assign pcTarget = pc + imm;
    assign newPc    = ctrl.jumpReg ? operands.arg3 : pcTarget;   // JR jumps to Rd

endmodule

`default_nettype wire

//--- src/decodeStage.sv
`default_nettype none

module decodeStage
    import decodePkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   latchEn,
    input  wire ifIdT   fetchIn,
    input  wire wbT     wb,
    input  wire logic   fwdSel1,
    input  wire logic   fwdSel2,
    input  wire wordT   fwdData,
    input  wire apbReqT apbReq,
    output apbRspT      apbRsp,
    output wordT        pcPlus2,
    output ctrlT        ctrl,
    output operandsT    operands,
    output wordT        imm,
    output regAddrT     rs1,
    output regAddrT     rs2,
    output regAddrT     rd,
    output wordT        newPc,
    output logic        branchTaken
);

    ifIdT stage;

    ifIdLatch u_ifIdLatch (
        .clk     (clk),
        .rst     (rst),
        .latchEn (latchEn),
        .fetchIn (fetchIn),
        .stage   (stage)
    );

    // register fields of the latched instruction
    assign rs1     = stage.ir[8:6];
    assign rs2     = stage.ir[11:9];
    assign rd      = stage.ir[5:3];
    assign pcPlus2 = stage.pcPlus2;

    controlDecoder u_controlDecoder (
        .ir   (stage.ir),
        .ctrl (ctrl)
    );

    registerFile u_registerFile (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wb       (wb),
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .operands (operands)
    );

    immediateGen u_immediateGen (
        .ir  (stage.ir),
        .imm (imm)
    );

    branchUnit u_branchUnit (
        .pc          (stage.pc),
        .ctrl        (ctrl),
        .ir          (stage.ir),
        .operands    (operands),
        .imm         (imm),
        .fwdSel1     (fwdSel1),
        .fwdSel2     (fwdSel2),
        .fwdData     (fwdData),
        .newPc       (newPc),
        .branchTaken (branchTaken)
    );

endmodule

`default_nettype wire

//--- tests/decodeStageTb.sv
`default_nettype none
`include "decode_params.svh"

module decodeStageTb
    import decodePkg::*;
();

    localparam int NUM_DECODE = 60;
    localparam int NUM_WB     = 40;
    localparam int NUM_BRANCH = 60;
    localparam int NUM_OPS    = 24 + NUM_DECODE + NUM_DECODE / 4 + NUM_WB + NUM_BRANCH + 1;

    logic     clk;
    logic     rst;
    logic     latchEn;
    ifIdT     fetchIn;
    wbT       wb;
    logic     fwdSel1;
    logic     fwdSel2;
    wordT     fwdData;
    apbReqT   apbReq;
    apbRspT   apbRsp;
    wordT     pcPlus2;
    ctrlT     ctrl;
    operandsT operands;
    wordT     imm;
    regAddrT  rs1;
    regAddrT  rs2;
    regAddrT  rd;
    wordT     newPc;
    logic     branchTaken;

    wordT   model [`REG_COUNT];   // mirror of the register file
    ifIdT   expStage;             // what the IF/ID latch should hold
    integer seed;
    int     errors;
    int     checks;
    logic   readyAtEdge;

    decodeStage u_decodeStage (
        .clk         (clk),
        .rst         (rst),
        .latchEn     (latchEn),
        .fetchIn     (fetchIn),
        .wb          (wb),
        .fwdSel1     (fwdSel1),
        .fwdSel2     (fwdSel2),
        .fwdData     (fwdData),
        .apbReq      (apbReq),
        .apbRsp      (apbRsp),
        .pcPlus2     (pcPlus2),
        .ctrl        (ctrl),
        .operands    (operands),
        .imm         (imm),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .newPc       (newPc),
        .branchTaken (branchTaken)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // every operation takes at most three cycles
    initial begin
        #(NUM_OPS * 8 * 4 + 500);
        $display("timeout: the run did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

    // ***********************************************************************
    // reference model
    // ***********************************************************************
    function automatic wordT randWord();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic ifIdT randomFetch(input logic branchOnly);
        ifIdT f;
        wordT pc;
        pc        = randWord();
        f.pc      = {pc[15:1], 1'b0};
        f.pcPlus2 = f.pc + 16'd2;
        f.ir      = randWord();
        if (branchOnly) begin
            f.ir[2] = 1'b1;   // opcodes 4..7 are BEQ, BNE, JAL and JR
        end
        return f;
    endfunction

    function automatic ctrlT expCtrl(input instrT ir);
        ctrlT       c;
        logic [2:0] op;
        op = ir[2:0];
        c  = '0;
        c.regWrite = (op == `OP_RTYPE || op == `OP_ADDI || op == `OP_LOAD || op == `OP_JAL)
            && (ir[5:3] != 3'd0);
        c.aluSrc   = (op == `OP_ADDI || op == `OP_LOAD || op == `OP_STORE);
        if (op == `OP_RTYPE && !ir[15]) begin
            c.aluOp = ir[14:12];   // codes 8..15 leave it at add
        end
        c.memWrite = (op == `OP_STORE);
        c.memRead  = (op == `OP_LOAD);
        if (op == `OP_LOAD) c.regStore = 2'd1;
        if (op == `OP_JAL) c.regStore = 2'd2;
        c.branch  = (op == `OP_BEQ || op == `OP_BNE);
        c.jump    = (op == `OP_JAL || op == `OP_JR);
        c.jumpReg = (op == `OP_JR);
        return c;
    endfunction

    function automatic wordT expImm(input instrT ir);
        logic signed [6:0]  s7;
        logic signed [12:0] s13;
        logic signed [15:0] r;
        r = '0;
        case (ir[2:0])
            `OP_ADDI, `OP_LOAD: begin
                s7 = ir[15:9];
                r  = s7;
            end
            `OP_STORE, `OP_BEQ, `OP_BNE: begin
                s7 = {ir[15:12], ir[5:3]};
                r  = s7;
            end
            `OP_JAL: begin
                s13 = ir[15:3];
                r   = s13;
                r   = r <<< 1;
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic checkOutputs();
        ctrlT  c;
        instrT ir;
        wordT  a;
        wordT  b;
        wordT  target;
        logic  taken;
        ir = expStage.ir;
        c  = expCtrl(ir);
        checkValue("ctrl", ctrl, c);
        checkValue("imm", imm, expImm(ir));
        checkValue("rs1", rs1, ir[8:6]);
        checkValue("rs2", rs2, ir[11:9]);
        checkValue("rd", rd, ir[5:3]);
        checkValue("operands.arg1", operands.arg1, model[ir[8:6]]);
        checkValue("operands.arg2", operands.arg2, model[ir[11:9]]);
        checkValue("operands.arg3", operands.arg3, model[ir[5:3]]);
        checkValue("pcPlus2", pcPlus2, expStage.pcPlus2);

        a      = fwdSel1 ? fwdData : model[ir[8:6]];
        b      = fwdSel2 ? fwdData : model[ir[11:9]];
        taken  = c.jump || (c.branch && ((ir[2:0] == `OP_BNE) ? (a != b) : (a == b)));
        target = (ir[2:0] == `OP_JR) ? model[ir[5:3]] : expStage.pc + expImm(ir);
        checkValue("branchTaken", branchTaken, taken);
        checkValue("newPc", newPc, target);

        checkValue("apbRsp.pready", apbRsp.pready, !wb.write);
        checkValue("apbRsp.prdata", apbRsp.prdata,
            (apbReq.psel && apbReq.penable) ? model[apbReq.paddr[2:0]] : 16'h0000);
    endtask

    // check the settled outputs, then step the model across the next edge
    task automatic cycle();
        ifIdT    nextStage;
        logic    wrEn;
        regAddrT wrAddr;
        wordT    wrData;
        #2;
        checkOutputs();
        readyAtEdge = apbRsp.pready;
        nextStage   = latchEn ? fetchIn : expStage;
        wrEn        = 1'b0;
        wrAddr      = '0;
        wrData      = '0;
        if (wb.write) begin
            wrEn   = 1'b1;
            wrAddr = wb.addr;
            wrData = wb.data;
        end else if (apbReq.psel && apbReq.penable && apbReq.pwrite) begin
            wrEn   = 1'b1;
            wrAddr = apbReq.paddr[2:0];
            wrData = apbReq.pwdata;
        end
        @(posedge clk);
        expStage = nextStage;
        if (wrEn && wrAddr != 3'd0) model[wrAddr] = wrData;
        #1;
    endtask

    // ***********************************************************************
    // host port transfers
    // ***********************************************************************
    task automatic apbTransfer(input logic write, input logic [3:0] addr, input wordT data,
                               input logic mixWb);
        int   waits;
        logic done;
        wordT r;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = data;
        wb.write       = 1'b0;
        cycle();
        apbReq.penable = 1'b1;
        done  = 1'b0;
        waits = 0;
        while (!done && waits < 4) begin
            r = randWord();
            if (mixWb && waits == 0 && r[0]) begin
                wb.write = 1'b1;   // a writeback in this cycle must stall the host
                wb.addr  = r[3:1];
                wb.data  = randWord();
            end else begin
                wb.write = 1'b0;
            end
            cycle();
            done = readyAtEdge;
            waits++;
        end
        if (!done) begin
            errors++;
            $display("APB transfer to address %h never completed", addr);
        end
        apbReq   = '0;
        wb.write = 1'b0;
    endtask

    initial begin
        int   i;
        wordT r;

        seed    = 32'h2e1ba8be;
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        latchEn = 1'b0;
        fetchIn = '0;
        wb      = '0;
        fwdSel1 = 1'b0;
        fwdSel2 = 1'b0;
        fwdData = '0;
        apbReq  = '0;
        expStage = '0;
        for (i = 0; i < `REG_COUNT; i++) begin
            model[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset leaves a bubble and an empty register file
        checkValue("control outputs after reset",
            {ctrl.regWrite, ctrl.memWrite, ctrl.memRead, ctrl.branch, ctrl.jump, branchTaken},
            6'b0);
        for (i = 0; i < `REG_COUNT; i++) begin
            apbTransfer(1'b0, i[3:0], 16'h0000, 1'b0);
        end

        // preload including a write to r0 with a random upper address bit
        for (i = 0; i < `REG_COUNT; i++) begin
            r = randWord();
            apbTransfer(1'b1, {r[0], i[2:0]}, randWord(), 1'b0);
        end
        for (i = 0; i < `REG_COUNT; i++) begin
            r = randWord();
            apbTransfer(1'b0, {r[0], i[2:0]}, 16'h0000, 1'b0);
        end

        // ***********************************************************************
        // decode with a stalled cycle now and then
        // ***********************************************************************
        for (i = 0; i < NUM_DECODE; i++) begin
            latchEn = 1'b1;
            fetchIn = randomFetch(1'b0);
            r       = randWord();
            fwdSel1 = r[0];
            fwdSel2 = r[1];
            fwdData = randWord();
            cycle();
            if (i % 4 == 3) begin
                latchEn = 1'b0;
                fetchIn = randomFetch(1'b0);
                cycle();
                checkOutputs();   // the held instruction must still be on every output
            end
        end
        latchEn = 1'b0;

        // writebacks mixed with host transfers
        for (i = 0; i < NUM_WB; i++) begin
            r = randWord();
            if (r[0]) begin
                apbTransfer(r[1], {r[2], r[5:3]}, randWord(), 1'b1);
            end else begin
                wb.write         = 1'b1;
                wb.addr          = r[8:6];
                wb.data          = randWord();
                latchEn          = 1'b1;
                fetchIn          = randomFetch(1'b0);
                fetchIn.ir[8:6]  = r[8:6];   // rs1 points at the register just written
                cycle();
                wb.write = 1'b0;
                latchEn  = 1'b0;
                cycle();
            end
        end

        // branches and jumps with random forwarding
        for (i = 0; i < NUM_BRANCH; i++) begin
            latchEn = 1'b1;
            fetchIn = randomFetch(1'b1);
            r       = randWord();
            fwdSel1 = r[0];
            fwdSel2 = r[1];
            fwdData = r[2] ? model[expStage.ir[11:9]] : randWord();
            cycle();
        end
        latchEn = 1'b0;
        cycle();

        $display("decodeStageTb done: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- decode.f
+incdir+src
src/decodePkg.sv
src/ifIdLatch.sv
src/controlDecoder.sv
src/registerFile.sv
src/immediateGen.sv
src/branchUnit.sv
src/decodeStage.sv
tests/decodeStageTb.sv
